// File: cps_sdram_bank0.f
verilog/cps_mem_pkg.sv
verilog/cps_addr_map.sv
verilog/cps_bank_sequencer.sv
verilog/cps_slot_cache.sv
verilog/cps_sdram_bank0.sv
testbench/cps_sdram_bank0_sva.sv
testbench/tb_cps_sdram_bank0.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the bank 0 testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -f cps_sdram_bank0.f \
    --top-module tb_cps_sdram_bank0 -o sim_cps_sdram_bank0
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/sim_cps_sdram_bank0 +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"

if grep -q "Done: errors found" "$log"; then
    echo "Simulation FAILED"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
echo "Simulation passed"
exit 0

// File: testbench/cps_sdram_bank0_sva.sv
module cps_sdram_bank0_sva
    import cps_mem_pkg::*;
#(
    parameter int ram_aw = 17,
    parameter int rom_aw = 21,
    parameter int snd_aw = 16
) (
    input logic              clk,
    input logic              arst_n,
    input logic              main_ram_cs,
    input logic              main_vram_cs,
    input logic              main_rnw,
    input logic [ram_aw-1:0] main_ram_addr,
    input logic [15:0]       main_dout,
    input logic [ 1:0]       dsn,
    input logic              main_rom_cs,
    input logic [rom_aw-1:0] main_rom_addr,
    input logic              snd_cs,
    input logic [snd_aw-1:0] snd_addr,
    input logic              main_ram_ok,
    input logic              main_rom_ok,
    input logic              snd_ok,
    input logic              ram_miss,
    input logic              rom_miss,
    input logic              snd_miss,
    input sdram_addr_t       ba_addr,
    input logic              ba_rd,
    input logic              ba_wr,
    input logic [15:0]       ba_din,
    input logic [ 1:0]       ba_din_m,
    input logic              ba_rdy
);

    int              fail_count = 0;   // Read by the testbench monitor
    logic            ram_cs;
    logic            start;
    logic            busy;             // From request until rdy
    logic            ram_rd_miss;
    logic            ram_last_v, rom_last_v, snd_last_v;
    logic [ram_aw:0] ram_key, ram_last;
    logic [rom_aw-1:0] rom_last;
    logic [snd_aw-1:0] snd_last;
    sdram_addr_t     exp_ram, exp_rom, exp_snd;

    assign ram_cs      = main_ram_cs | main_vram_cs;
    assign ram_key     = {main_vram_cs, main_ram_addr};
    assign start       = ba_rd | ba_wr;
    assign ram_rd_miss = ram_miss & main_rnw;
    assign exp_ram = (main_ram_cs ? wram_offset : vram_offset) + sdram_addr_t'(main_ram_addr);
    assign exp_rom = rom_offset + sdram_addr_t'(main_rom_addr);
    assign exp_snd = snd_offset + sdram_addr_t'(snd_addr[snd_aw-1:1]);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy       <= 1'b0;
            ram_last_v <= 1'b0;
            rom_last_v <= 1'b0;
            snd_last_v <= 1'b0;
        end else begin
            if (ba_rdy) busy <= 1'b0;
            else if (start) busy <= 1'b1;
            if (main_ram_ok && main_rnw) begin   // Last read is what the cache holds
                ram_last   <= ram_key;
                ram_last_v <= 1'b1;
            end
            if (main_rom_ok) begin
                rom_last   <= main_rom_addr;
                rom_last_v <= 1'b1;
            end
            if (snd_ok) begin
                snd_last   <= snd_addr;
                snd_last_v <= 1'b1;
            end
        end
    end

    a_reset: assert property (@(posedge clk) !arst_n |->
        !ba_rd && !ba_wr && !main_ram_ok && !main_rom_ok && !snd_ok)
        else begin fail_count++; $error("strobe or ok high during reset"); end

    a_one_strobe: assert property (@(posedge clk) !(ba_rd && ba_wr))
        else begin fail_count++; $error("ba_rd and ba_wr high together"); end

    a_no_overlap: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(start) |-> !busy)
        else begin fail_count++; $error("new SDRAM request before rdy"); end

    a_addr_map: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(start) |-> (ram_cs && ba_addr == exp_ram) ||
                         (main_rom_cs && ba_addr == exp_rom) ||
                         (snd_cs && ba_addr == exp_snd))
        else begin fail_count++; $error("ba_addr 0x%h matches no client", ba_addr); end

    a_wr_data: assert property (@(posedge clk) disable iff (!arst_n)
        ba_wr |-> ram_cs && !main_rnw && ba_din == main_dout && ba_din_m == dsn)
        else begin fail_count++; $error("write data or mask differs from client"); end

    // Issue edge samples the two idle cycles before it through $past
    a_ram_first: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(start) && (ba_addr < vram_offset || ba_addr >= snd_offset) |->
        !($past(ram_rd_miss) && $past(ram_rd_miss, 2)))
        else begin fail_count++; $error("lower slot served before pending RAM read"); end

    a_rom_first: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(start) && ba_addr >= snd_offset |-> !($past(rom_miss) && $past(rom_miss, 2)))
        else begin fail_count++; $error("sound slot served before pending ROM read"); end

    a_ram_release: assert property (@(posedge clk) disable iff (!arst_n)
        !ram_cs |=> !main_ram_ok)
        else begin fail_count++; $error("RAM ok still high after cs fell"); end

    a_rom_release: assert property (@(posedge clk) disable iff (!arst_n)
        !main_rom_cs |=> !main_rom_ok)
        else begin fail_count++; $error("ROM ok still high after cs fell"); end

    a_snd_release: assert property (@(posedge clk) disable iff (!arst_n)
        !snd_cs |=> !snd_ok)
        else begin fail_count++; $error("sound ok still high after cs fell"); end

    // A hit asks the sequencer for nothing
    a_ram_hit: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(ram_cs) && main_rnw && ram_last_v && ram_key == ram_last |=>
        main_ram_ok && !$past(ram_miss))
        else begin fail_count++; $error("repeated RAM read missed the slot cache"); end

    a_rom_hit: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(main_rom_cs) && rom_last_v && main_rom_addr == rom_last |=>
        main_rom_ok && !$past(rom_miss))
        else begin fail_count++; $error("repeated ROM read missed the slot cache"); end

    a_snd_hit: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(snd_cs) && snd_last_v && snd_addr == snd_last |=>
        snd_ok && !$past(snd_miss))
        else begin fail_count++; $error("repeated sound read missed the slot cache"); end

endmodule

bind cps_sdram_bank0 cps_sdram_bank0_sva #(
    .ram_aw ( ram_aw ),
    .rom_aw ( rom_aw ),
    .snd_aw ( snd_aw )
) i_sva (.*);

// File: testbench/tb_cps_sdram_bank0.sv
module tb_cps_sdram_bank0
    import cps_mem_pkg::*;
();

    localparam int n_acc      = 40;                 // Accesses per client
    localparam int max_cycles = 4 * 3 * n_acc * 12;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        main_ram_cs, main_vram_cs, main_rnw;
    logic [16:0] main_ram_addr;
    logic [15:0] main_dout;
    logic [ 1:0] dsn;
    logic        main_rom_cs;
    logic [20:0] main_rom_addr;
    logic        snd_cs;
    logic [15:0] snd_addr;
    logic        main_ram_ok, main_rom_ok, snd_ok;
    logic [15:0] main_ram_data, main_rom_data;
    logic [ 7:0] snd_data;
    sdram_addr_t ba_addr;
    logic        ba_rd, ba_wr, ba_ack, ba_dst, ba_rdy;
    logic [15:0] ba_din, data_read;
    logic [ 1:0] ba_din_m;

    logic [15:0] mem [sdram_addr_t];   // Written words only
    int          seed   = 38;
    int          errors = 0;
    int          cycles = 0;

    always #5 clk = ~clk;

    cps_sdram_bank0 #(.ram_aw(17), .rom_aw(21), .snd_aw(16)) i_cps_sdram_bank0 (.*);

    function automatic logic [15:0] model_word(sdram_addr_t a);
        if (mem.exists(a)) return mem[a];
        return a[15:0] ^ {a[22:16], a[22:14]};   // Fill pattern over the whole address
    endfunction

    task automatic check_data(string name, logic [15:0] got, logic [15:0] exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    // SDRAM bank model acks after 1 to 4 cycles then gives dst and rdy
    initial begin : sdram_model
        sdram_addr_t a;
        logic [15:0] w;
        int          delay;
        forever begin
            @(negedge clk);
            if (ba_rd || ba_wr) begin
                a     = ba_addr;
                delay = 1 + ($random(seed) & 3);
                repeat (delay) @(posedge clk);
                ba_ack <= 1'b1;
                if (ba_wr) begin
                    w = model_word(a);
                    if (!ba_din_m[1]) w[15:8] = ba_din[15:8];
                    if (!ba_din_m[0]) w[7:0] = ba_din[7:0];
                    mem[a] = w;
                end
                @(posedge clk);
                ba_ack    <= 1'b0;
                ba_dst    <= 1'b1;
                data_read <= model_word(a);
                @(posedge clk);
                ba_dst <= 1'b0;
                ba_rdy <= 1'b1;
                @(posedge clk);
                ba_rdy <= 1'b0;
            end
        end
    end

    task automatic ram_traffic();
        int          r;
        logic [16:0] a = '0;
        logic        vr = 1'b0;
        logic        wr;
        for (int i = 0; i < n_acc; i++) begin
            r = $random(seed);
            if (r[3:2] != 2'b00) begin   // Otherwise repeat the last address
                a  = 17'(r[31:28]);
                vr = r[27];
            end
            wr = (r[5:4] == 2'b00);
            @(posedge clk);
            main_ram_cs   <= ~vr;
            main_vram_cs  <= vr;
            main_rnw      <= ~wr;
            main_ram_addr <= a;
            main_dout     <= r[23:8];
            dsn           <= r[7:6];
            do @(negedge clk); while (!main_ram_ok);
            if (!wr) check_data("main_ram_data", main_ram_data,
                model_word((vr ? vram_offset : wram_offset) + sdram_addr_t'(a)));
            @(posedge clk);
            main_ram_cs  <= 1'b0;
            main_vram_cs <= 1'b0;
        end
    endtask

    task automatic rom_traffic();
        int          r;
        logic [20:0] a = '0;
        for (int i = 0; i < n_acc; i++) begin
            r = $random(seed);
            if (r[1:0] != 2'b00) a = 21'(r[31:27]);
            @(posedge clk);
            main_rom_cs   <= 1'b1;
            main_rom_addr <= a;
            do @(negedge clk); while (!main_rom_ok);
            check_data("main_rom_data", main_rom_data, model_word(rom_offset + sdram_addr_t'(a)));
            @(posedge clk);
            main_rom_cs <= 1'b0;
        end
    endtask

    task automatic snd_traffic();
        int          r;
        logic [15:0] a = '0;
        logic [15:0] w;
        for (int i = 0; i < n_acc; i++) begin
            r = $random(seed);
            if (r[1:0] != 2'b00) a = 16'(r[31:26]);
            @(posedge clk);
            snd_cs   <= 1'b1;
            snd_addr <= a;
            do @(negedge clk); while (!snd_ok);
            w = model_word(snd_offset + sdram_addr_t'(a >> 1));
            check_data("snd_data", {8'h00, snd_data}, {8'h00, a[0] ? w[15:8] : w[7:0]});
            @(posedge clk);
            snd_cs <= 1'b0;
        end
    endtask

    // Stops the run at the first failed check or on timeout
    always @(posedge clk) begin
        cycles++;
        if (errors != 0 || i_cps_sdram_bank0.i_sva.fail_count != 0) begin
            $display("Done: errors found");
            $fatal(1, "Stopped at the first failed check");
        end else if (cycles >= max_cycles) begin
            $display("Timeout: clients still waiting for ok after %0d cycles", cycles);
            $display("Done: errors found");
            $fatal(1, "Stopped on timeout");
        end
    end

    initial begin
        arst_n        = 1'b0;
        main_ram_cs   = 1'b0;
        main_vram_cs  = 1'b0;
        main_rnw      = 1'b1;
        main_ram_addr = '0;
        main_dout     = '0;
        dsn           = 2'b11;
        main_rom_cs   = 1'b0;
        main_rom_addr = '0;
        snd_cs        = 1'b0;
        snd_addr      = '0;
        ba_ack        = 1'b0;
        ba_dst        = 1'b0;
        ba_rdy        = 1'b0;
        data_read     = '0;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        fork
            ram_traffic();
            rom_traffic();
            snd_traffic();
        join
        repeat (4) @(posedge clk);
        if (errors == 0 && i_cps_sdram_bank0.i_sva.fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: verilog/cps_addr_map.sv
module cps_addr_map
    import cps_mem_pkg::*;
#(
    parameter int ram_aw = 17,
    parameter int rom_aw = 21,
    parameter int snd_aw = 16
) (
    // Main CPU RAM and VRAM
    input  logic              main_ram_cs,
    input  logic              main_vram_cs,
    input  logic              main_rnw,
    input  logic [ram_aw-1:0] main_ram_addr,
    input  logic [15:0]       main_dout,
    input  logic [ 1:0]       dsn,

    // Main CPU ROM
    input  logic              main_rom_cs,
    input  logic [rom_aw-1:0] main_rom_addr,

    // Sound CPU ROM, byte address
    input  logic              snd_cs,
    input  logic [snd_aw-1:0] snd_addr,

    output slot_req_t         ram_req,
    output slot_req_t         rom_req,
    output slot_req_t         snd_req
);

    logic        ram_slot_cs;
    sdram_addr_t ram_offset;
    logic [20:0] ram_tag;
    logic [snd_aw-2:0] snd_word;

    // Work RAM and VRAM share one slot
    assign ram_slot_cs = main_ram_cs | main_vram_cs;
    assign ram_offset  = main_ram_cs ? wram_offset : vram_offset;
    assign snd_word    = snd_addr[snd_aw-1:1];

    always_comb begin
        // Top tag bit tells VRAM from work RAM, so the cache
        // never confuses the same CPU address in both regions
        ram_tag     = 21'(main_ram_addr);
        ram_tag[20] = ~main_ram_cs;

        ram_req.cs     = ram_slot_cs;
        ram_req.wr     = ram_slot_cs & ~main_rnw;
        ram_req.addr   = ram_offset + sdram_addr_t'(main_ram_addr);
        ram_req.tag    = ram_tag;
        ram_req.din    = main_dout;
        ram_req.wrmask = dsn;
    end

    always_comb begin
        rom_req.cs     = main_rom_cs;
        rom_req.wr     = 1'b0;          // Read only
        rom_req.addr   = rom_offset + sdram_addr_t'(main_rom_addr);
        rom_req.tag    = 21'(main_rom_addr);
        rom_req.din    = '0;
        rom_req.wrmask = 2'b11;
    end

    always_comb begin
        snd_req.cs     = snd_cs;
        snd_req.wr     = 1'b0;
        // Byte address halved to a word, byte select stays in tag[0]
        snd_req.addr   = snd_offset + sdram_addr_t'(snd_word);
        snd_req.tag    = 21'(snd_addr);
        snd_req.din    = '0;
        snd_req.wrmask = 2'b11;
    end

endmodule

// File: verilog/cps_bank_sequencer.sv
module cps_bank_sequencer
    import cps_mem_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,

    input  slot_req_t   ram_req,
    input  slot_req_t   rom_req,
    input  slot_req_t   snd_req,
    input  logic        ram_miss,
    input  logic        rom_miss,
    input  logic        snd_miss,

    // SDRAM bank 0
    input  sdram_ret_t  sdram_ret,
    input  logic        ba_ack,
    output sdram_addr_t ba_addr,
    output logic        ba_rd,
    output logic        ba_wr,
    output logic [15:0] ba_din,
    output logic [ 1:0] ba_din_m,

    output slot_fill_t  ram_fill,
    output slot_fill_t  rom_fill,
    output slot_fill_t  snd_fill
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait_ack,
        st_wait_dst,
        st_wait_rdy
    } state_e;

    state_e                 state;
    slot_e                  served;
    slot_e                  next_slot;
    slot_req_t              next_req;
    logic [num_slots-1:0]   pend_now;
    logic [num_slots-1:0]   pend_q;    // Misses seen one cycle late
    logic [num_slots-1:0]   pick;
    logic                   wr_done;   // Write accepted during this cs
    logic                   fill_stb;
    logic [20:0]            cur_tag;
    sdram_addr_t            cur_addr;
    logic [15:0]            cur_din;
    logic [ 1:0]            cur_mask;
    logic [ 7:0]            snd_byte;

    assign pend_now[slot_ram] = ram_miss & ~(ram_req.wr & wr_done);
    assign pend_now[slot_rom] = rom_miss;
    assign pend_now[slot_snd] = snd_miss;

    // Still missing now, so a dropped cs is never served
    assign pick = pend_q & pend_now;

    always_comb begin
        next_slot = slot_ram;
        next_req  = ram_req;
        if (pick[slot_ram]) begin
            next_slot = slot_ram;
            next_req  = ram_req;
        end else if (pick[slot_rom]) begin
            next_slot = slot_rom;
            next_req  = rom_req;
        end else if (pick[slot_snd]) begin
            next_slot = slot_snd;
            next_req  = snd_req;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= st_idle;
            served  <= slot_ram;
            ba_rd   <= 1'b0;
            ba_wr   <= 1'b0;
            pend_q  <= '0;
            wr_done <= 1'b0;
        end else begin
            pend_q <= pend_now;
            if (!ram_req.cs || !ram_req.wr) begin
                wr_done <= 1'b0;
            end else if (state == st_wait_ack && ba_ack && ba_wr) begin
                wr_done <= 1'b1;
            end
            case (state)
                st_idle: begin
                    if (|pick) begin
                        served <= next_slot;
                        ba_rd  <= ~next_req.wr;
                        ba_wr  <= next_req.wr;
                        state  <= st_wait_ack;
                    end
                end
                st_wait_ack: begin
                    if (ba_ack) begin
                        ba_rd <= 1'b0;
                        ba_wr <= 1'b0;
                        state <= st_wait_dst;
                    end
                end
                st_wait_dst: if (sdram_ret.dst) state <= st_wait_rdy;
                st_wait_rdy: if (sdram_ret.rdy) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    // Request latched at start, held stable until rdy
    always_ff @(posedge clk) begin
        if (state == st_idle && |pick) begin
            cur_addr <= next_req.addr;
            cur_tag  <= next_req.tag;
            cur_din  <= next_req.din;
            cur_mask <= next_req.wrmask;
        end
    end

    assign ba_addr  = cur_addr;
    assign ba_din   = cur_din;
    assign ba_din_m = cur_mask;

    assign fill_stb = (state == st_wait_dst) && sdram_ret.dst;
    assign snd_byte = cur_tag[0] ? sdram_ret.data[15:8] : sdram_ret.data[7:0];

    always_comb begin
        ram_fill = '{valid: fill_stb && served == slot_ram, tag: cur_tag,
                     word: sdram_ret.data};
        rom_fill = '{valid: fill_stb && served == slot_rom, tag: cur_tag,
                     word: sdram_ret.data};
        snd_fill = '{valid: fill_stb && served == slot_snd, tag: cur_tag,
                     word: {8'h00, snd_byte}};
    end

endmodule

// File: verilog/cps_mem_pkg.sv
package cps_mem_pkg;

    // SDRAM word address, 8M words per bank
    typedef logic [22:0] sdram_addr_t;

    // Region bases inside bank 0
    localparam sdram_addr_t vram_offset = 23'h20_0000;
    localparam sdram_addr_t wram_offset = 23'h30_0000;
    localparam sdram_addr_t snd_offset  = 23'h38_0000;
    localparam sdram_addr_t rom_offset  = 23'h00_0000;

    // Slot order is also the arbitration order, highest first
    typedef enum logic [1:0] {
        slot_ram = 2'd0,   // Work RAM and VRAM, read and write
        slot_rom = 2'd1,   // Main CPU ROM
        slot_snd = 2'd2    // Sound CPU ROM, byte wide
    } slot_e;

    localparam int num_slots = 3;

    // One client request after address decode
    typedef struct packed {
        logic        cs;
        logic        wr;       // Only ever set on the RAM slot
        sdram_addr_t addr;     // Region offset already added
        logic [20:0] tag;      // Client address, used by the slot cache
        logic [15:0] din;
        logic [ 1:0] wrmask;   // Active low per byte, like dsn
    } slot_req_t;

    // SDRAM return strobes and read data
    typedef struct packed {
        logic        dst;      // data_read valid this cycle
        logic        rdy;      // Transfer finished
        logic [15:0] data;
    } sdram_ret_t;

    // Sequencer to cache, one pulse per finished access
    typedef struct packed {
        logic        valid;
        logic [20:0] tag;
        logic [15:0] word;     // Sound slot gets its byte in the low half
    } slot_fill_t;

endpackage

// File: verilog/cps_sdram_bank0.sv
module cps_sdram_bank0
    import cps_mem_pkg::*;
#(
    parameter int ram_aw = 17,
    parameter int rom_aw = 21,
    parameter int snd_aw = 16
) (
    input  logic              clk,
    input  logic              arst_n,

    // Main CPU RAM and VRAM
    input  logic              main_ram_cs,
    input  logic              main_vram_cs,
    input  logic              main_rnw,
    input  logic [ram_aw-1:0] main_ram_addr,
    input  logic [15:0]       main_dout,
    input  logic [ 1:0]       dsn,
    output logic              main_ram_ok,
    output logic [15:0]       main_ram_data,

    // Main CPU ROM
    input  logic              main_rom_cs,
    input  logic [rom_aw-1:0] main_rom_addr,
    output logic              main_rom_ok,
    output logic [15:0]       main_rom_data,

    // Sound CPU ROM
    input  logic              snd_cs,
    input  logic [snd_aw-1:0] snd_addr,
    output logic              snd_ok,
    output logic [ 7:0]       snd_data,

    // SDRAM bank 0
    output sdram_addr_t       ba_addr,
    output logic              ba_rd,
    output logic              ba_wr,
    output logic [15:0]       ba_din,
    output logic [ 1:0]       ba_din_m,
    input  logic              ba_ack,
    input  logic              ba_dst,
    input  logic              ba_rdy,
    input  logic [15:0]       data_read
);

    slot_req_t  ram_req, rom_req, snd_req;
    slot_fill_t ram_fill, rom_fill, snd_fill;
    logic       ram_miss, rom_miss, snd_miss;
    sdram_ret_t sdram_ret;

    assign sdram_ret = '{dst: ba_dst, rdy: ba_rdy, data: data_read};

    cps_addr_map #(
        .ram_aw        ( ram_aw        ),
        .rom_aw        ( rom_aw        ),
        .snd_aw        ( snd_aw        )
    ) i_addr_map (
        .main_ram_cs   ( main_ram_cs   ),
        .main_vram_cs  ( main_vram_cs  ),
        .main_rnw      ( main_rnw      ),
        .main_ram_addr ( main_ram_addr ),
        .main_dout     ( main_dout     ),
        .dsn           ( dsn           ),
        .main_rom_cs   ( main_rom_cs   ),
        .main_rom_addr ( main_rom_addr ),
        .snd_cs        ( snd_cs        ),
        .snd_addr      ( snd_addr      ),
        .ram_req       ( ram_req       ),
        .rom_req       ( rom_req       ),
        .snd_req       ( snd_req       )
    );

    cps_bank_sequencer i_sequencer (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .ram_req   ( ram_req   ),
        .rom_req   ( rom_req   ),
        .snd_req   ( snd_req   ),
        .ram_miss  ( ram_miss  ),
        .rom_miss  ( rom_miss  ),
        .snd_miss  ( snd_miss  ),
        .sdram_ret ( sdram_ret ),
        .ba_ack    ( ba_ack    ),
        .ba_addr   ( ba_addr   ),
        .ba_rd     ( ba_rd     ),
        .ba_wr     ( ba_wr     ),
        .ba_din    ( ba_din    ),
        .ba_din_m  ( ba_din_m  ),
        .ram_fill  ( ram_fill  ),
        .rom_fill  ( rom_fill  ),
        .snd_fill  ( snd_fill  )
    );

    cps_slot_cache #(.payload_t(logic [15:0])) i_ram_cache (
        .clk    ( clk           ),
        .arst_n ( arst_n        ),
        .req    ( ram_req       ),
        .fill   ( ram_fill      ),
        .miss   ( ram_miss      ),
        .ok     ( main_ram_ok   ),
        .dout   ( main_ram_data )
    );

    cps_slot_cache #(.payload_t(logic [15:0])) i_rom_cache (
        .clk    ( clk           ),
        .arst_n ( arst_n        ),
        .req    ( rom_req       ),
        .fill   ( rom_fill      ),
        .miss   ( rom_miss      ),
        .ok     ( main_rom_ok   ),
        .dout   ( main_rom_data )
    );

    // Byte wide sound CPU
    cps_slot_cache #(.payload_t(logic [7:0])) i_snd_cache (
        .clk    ( clk      ),
        .arst_n ( arst_n   ),
        .req    ( snd_req  ),
        .fill   ( snd_fill ),
        .miss   ( snd_miss ),
        .ok     ( snd_ok   ),
        .dout   ( snd_data )
    );

endmodule

// File: verilog/cps_slot_cache.sv
module cps_slot_cache
    import cps_mem_pkg::*;
#(
    parameter type payload_t = logic [15:0]
) (
    input  logic       clk,
    input  logic       arst_n,
    input  slot_req_t  req,
    input  slot_fill_t fill,
    output logic       miss,
    output logic       ok,
    output payload_t   dout
);

    logic        valid;
    logic [20:0] tag;
    payload_t    word;
    logic        wr_done;     // Write of this cs already in SDRAM
    logic        tag_hit;
    logic        fill_match;
    logic        fill_rd;
    logic        wr_merge;
    logic [15:0] cur_word;
    logic [15:0] merged;

    assign tag_hit    = valid && (tag == req.tag);
    assign miss       = req.cs && (req.wr || !tag_hit);   // Writes always go out
    assign fill_match = fill.valid && req.cs && (fill.tag == req.tag);
    assign fill_rd    = fill.valid && !req.wr;
    assign wr_merge   = fill_match && req.wr && tag_hit;

    // Byte merge for a write that hits the stored entry
    assign cur_word = 16'(word);
    assign merged   = {req.wrmask[1] ? cur_word[15:8] : req.din[15:8],
                       req.wrmask[0] ? cur_word[ 7:0] : req.din[ 7:0]};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid   <= 1'b0;
            ok      <= 1'b0;
            wr_done <= 1'b0;
        end else begin
            if (fill_rd) valid <= 1'b1;
            wr_done <= req.cs && req.wr && (wr_done || fill_match);
            if (req.wr) begin
                ok <= req.cs && (wr_done || fill_match);
            end else begin
                ok <= req.cs && (tag_hit || fill_match);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_rd) begin
            tag  <= fill.tag;
            word <= payload_t'(fill.word);
        end else if (wr_merge) begin
            word <= payload_t'(merged);
        end
    end

    assign dout = word;

endmodule
